// File: hdl/be_pkg.sv
package be_pkg;

  // datapath and address width
  localparam int CPU_WIDTH  = 32;
  localparam int INS_WIDTH  = 32;
  localparam int REG_ADDRW  = 5;

  // one enable bit per byte lane
  localparam int BE_WIDTH   = CPU_WIDTH / 8;

  // local data memory, word organized
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_IDXW  = $clog2(DMEM_WORDS);

  // addresses with this bit set go to the device port
  localparam int DEV_BIT    = 31;

  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LH   = 4'd2,
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,
    LSU_LHU  = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_e;

  function automatic logic lsu_is_load(lsu_op_e op);
    return op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
  endfunction

  function automatic logic lsu_is_store(lsu_op_e op);
    return op inside {LSU_SB, LSU_SH, LSU_SW};
  endfunction

endpackage

// File: hdl/lsu.sv
`timescale 1ns/10ps

module lsu (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // from execute
  input  logic                          i_pre_valid,
  output logic                          o_pre_ready,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_exres,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_rs2,
  input  logic [be_pkg::REG_ADDRW-1:0]  i_exu_rdid,
  input  logic                          i_exu_rdwen,
  input  be_pkg::lsu_op_e               i_exu_lsop,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_pc,
  input  logic [be_pkg::INS_WIDTH-1:0]  i_exu_ins,

  // to writeback
  output logic                          o_post_valid,
  input  logic                          i_post_ready,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_lsu_exres,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_lsu_lsres,
  output logic [be_pkg::REG_ADDRW-1:0]  o_lsu_rdid,
  output logic                          o_lsu_rdwen,
  output logic                          o_lsu_lden,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_lsu_pc,
  output logic [be_pkg::INS_WIDTH-1:0]  o_lsu_ins,
  output logic                          o_lsu_device,

  // local data memory
  output logic [be_pkg::DMEM_IDXW-1:0]  o_mem_idx,
  output logic [be_pkg::BE_WIDTH-1:0]   o_mem_be,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_mem_wdata,
  output logic                          o_mem_we,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_mem_rdata,

  // external device
  output logic                          o_dev_req,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_dev_addr,
  output logic                          o_dev_we,
  output logic [be_pkg::BE_WIDTH-1:0]   o_dev_be,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_dev_wdata,
  input  logic                          i_dev_ack,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_dev_rdata
);

  import be_pkg::*;

  logic                 valid_r;
  logic                 acked_r;
  logic [CPU_WIDTH-1:0] exres_r;
  logic [CPU_WIDTH-1:0] rs2_r;
  logic [REG_ADDRW-1:0] rdid_r;
  logic                 rdwen_r;
  lsu_op_e              lsop_r;
  logic [CPU_WIDTH-1:0] pc_r;
  logic [INS_WIDTH-1:0] ins_r;
  logic [CPU_WIDTH-1:0] dev_rdata_r;

  logic                 pre_sh;
  logic                 post_sh;
  logic                 is_load;
  logic                 is_store;
  logic                 is_dev;
  logic [BE_WIDTH-1:0]  be;
  logic [CPU_WIDTH-1:0] wdata;
  logic [CPU_WIDTH-1:0] raw_word;
  logic [CPU_WIDTH-1:0] lane_word;
  logic [CPU_WIDTH-1:0] lsres;

  // stage is free when empty or when its content leaves this cycle
  assign o_pre_ready = !valid_r || post_sh;
  assign pre_sh      = i_pre_valid && o_pre_ready;
  assign post_sh     = o_post_valid && i_post_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_r <= 1'b0;
      acked_r <= 1'b0;
    end else begin
      if (o_pre_ready) begin
        valid_r <= i_pre_valid;
      end
      // remember an ack that could not leave the stage yet
      if (post_sh) begin
        acked_r <= 1'b0;
      end else if (i_dev_ack) begin
        acked_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (pre_sh) begin
      exres_r <= i_exu_exres;
      rs2_r   <= i_exu_rs2;
      rdid_r  <= i_exu_rdid;
      rdwen_r <= i_exu_rdwen;
      lsop_r  <= i_exu_lsop;
      pc_r    <= i_exu_pc;
      ins_r   <= i_exu_ins;
    end
    if (i_dev_ack) begin
      dev_rdata_r <= i_dev_rdata;
    end
  end

  assign is_load  = lsu_is_load(lsop_r);
  assign is_store = lsu_is_store(lsop_r);
  // only memory ops look at the region bit since pass-through results may be negative
  assign is_dev   = (is_load || is_store) && exres_r[DEV_BIT];

  // byte lane from the low address bits
  always_comb begin
    case (lsop_r)
      LSU_LB, LSU_LBU, LSU_SB: be = 4'b0001 << exres_r[1:0];
      LSU_LH, LSU_LHU, LSU_SH: be = 4'b0011 << {exres_r[1], 1'b0};
      LSU_LW, LSU_SW:          be = 4'b1111;
      default:                 be = '0;
    endcase
  end

  assign wdata = rs2_r << {exres_r[1:0], 3'b000};

  assign raw_word  = is_dev ? (acked_r ? dev_rdata_r : i_dev_rdata) : i_mem_rdata;
  assign lane_word = raw_word >> {exres_r[1:0], 3'b000};

  always_comb begin
    case (lsop_r)
      LSU_LB:  lsres = {{24{lane_word[7]}}, lane_word[7:0]};
      LSU_LBU: lsres = {24'b0, lane_word[7:0]};
      LSU_LH:  lsres = {{16{lane_word[15]}}, lane_word[15:0]};
      LSU_LHU: lsres = {16'b0, lane_word[15:0]};
      LSU_LW:  lsres = lane_word;
      default: lsres = '0;
    endcase
  end

  // device accesses wait for the acknowledge
  assign o_post_valid = valid_r && (!is_dev || i_dev_ack || acked_r);

  assign o_lsu_exres  = exres_r;
  assign o_lsu_lsres  = lsres;
  assign o_lsu_rdid   = rdid_r;
  assign o_lsu_rdwen  = rdwen_r;
  assign o_lsu_lden   = is_load;
  assign o_lsu_pc     = pc_r;
  assign o_lsu_ins    = ins_r;
  assign o_lsu_device = is_dev;

  assign o_mem_idx   = exres_r[DMEM_IDXW+1:2];
  assign o_mem_be    = be;
  assign o_mem_wdata = wdata;
  // write once in the cycle the store leaves the stage
  assign o_mem_we    = post_sh && is_store && !is_dev;

  assign o_dev_req   = valid_r && is_dev && !acked_r;
  assign o_dev_addr  = exres_r;
  assign o_dev_we    = is_store;
  assign o_dev_be    = be;
  assign o_dev_wdata = wdata;

  a_ack_needs_req: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_dev_ack |-> o_dev_req
  ) else $error("device ack without a pending request");

  // a device request stays up with a steady address until its acknowledge
  a_dev_req_held: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      o_dev_req && !i_dev_ack |=> o_dev_req && $stable(o_dev_addr)
  ) else $error("device request dropped or changed before its acknowledge");

endmodule

// File: hdl/dmem.sv
`timescale 1ns/10ps

module dmem (
  input  logic                          i_clk,
  input  logic [be_pkg::DMEM_IDXW-1:0]  i_mem_idx,
  input  logic [be_pkg::BE_WIDTH-1:0]   i_mem_be,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_mem_wdata,
  input  logic                          i_mem_we,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_mem_rdata
);

  import be_pkg::*;

  logic [CPU_WIDTH-1:0] mem [DMEM_WORDS];

  // byte-enabled write on the clock edge
  always_ff @(posedge i_clk) begin
    if (i_mem_we) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (i_mem_be[b]) begin
          mem[i_mem_idx][b*8 +: 8] <= i_mem_wdata[b*8 +: 8];
        end
      end
    end
  end

  // combinational read of the whole word with the lane picked in lsu
  assign o_mem_rdata = mem[i_mem_idx];

endmodule

// File: hdl/wbu.sv
`timescale 1ns/10ps

module wbu (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // from load/store stage
  input  logic                          i_pre_valid,
  output logic                          o_pre_ready,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_lsu_exres,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_lsu_lsres,
  input  logic [be_pkg::REG_ADDRW-1:0]  i_lsu_rdid,
  input  logic                          i_lsu_rdwen,
  input  logic                          i_lsu_lden,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_lsu_pc,
  input  logic [be_pkg::INS_WIDTH-1:0]  i_lsu_ins,
  input  logic                          i_lsu_device,

  // register write and trace
  output logic                          o_wbu_rdwen,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_wbu_rd,
  output logic [be_pkg::REG_ADDRW-1:0]  o_wbu_rdid,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_wbu_pc,
  output logic [be_pkg::INS_WIDTH-1:0]  o_wbu_ins,
  output logic                          o_wbu_device
);

  import be_pkg::*;

  logic                 valid_r;
  logic [CPU_WIDTH-1:0] exres_r;
  logic [CPU_WIDTH-1:0] lsres_r;
  logic [REG_ADDRW-1:0] rdid_r;
  logic                 rdwen_r;
  logic                 lden_r;
  logic [CPU_WIDTH-1:0] pc_r;
  logic [INS_WIDTH-1:0] ins_r;
  logic                 device_r;

  // register file takes a write every cycle so this stage never stalls
  assign o_pre_ready = 1'b1;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= i_pre_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_pre_valid) begin
      exres_r  <= i_lsu_exres;
      lsres_r  <= i_lsu_lsres;
      rdid_r   <= i_lsu_rdid;
      rdwen_r  <= i_lsu_rdwen;
      lden_r   <= i_lsu_lden;
      pc_r     <= i_lsu_pc;
      ins_r    <= i_lsu_ins;
      device_r <= i_lsu_device;
    end
  end

  assign o_wbu_rdwen  = valid_r && rdwen_r;
  assign o_wbu_rd     = lden_r ? lsres_r : exres_r;
  assign o_wbu_rdid   = rdid_r;
  assign o_wbu_pc     = pc_r;
  assign o_wbu_ins    = ins_r;
  assign o_wbu_device = device_r;

  // a register write carries a known index and data
  a_wen_known: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
      o_wbu_rdwen |-> !$isunknown({o_wbu_rdid, o_wbu_rd})
  ) else $error("register write with unknown index or data");

endmodule

// File: hdl/regfile.sv
`timescale 1ns/10ps

module regfile (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_wen,
  input  logic [be_pkg::REG_ADDRW-1:0]  i_wid,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_wdata,
  input  logic [be_pkg::REG_ADDRW-1:0]  i_rid,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_rdata
);

  import be_pkg::*;

  logic [CPU_WIDTH-1:0] regs [2**REG_ADDRW];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2**REG_ADDRW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_wid != '0)) begin
      // x0 is never written
      regs[i_wid] <= i_wdata;
    end
  end

  assign o_rdata = regs[i_rid];

endmodule

// File: hdl/be_top.sv
`timescale 1ns/10ps

module be_top (
  input  logic                          i_clk,
  input  logic                          i_rst_n,

  // execute side
  input  logic                          i_exu_valid,
  output logic                          o_exu_ready,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_exres,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_rs2,
  input  logic [be_pkg::REG_ADDRW-1:0]  i_exu_rdid,
  input  logic                          i_exu_rdwen,
  input  be_pkg::lsu_op_e               i_exu_lsop,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_exu_pc,
  input  logic [be_pkg::INS_WIDTH-1:0]  i_exu_ins,

  // device port
  output logic                          o_dev_req,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_dev_addr,
  output logic                          o_dev_we,
  output logic [be_pkg::BE_WIDTH-1:0]   o_dev_be,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_dev_wdata,
  input  logic                          i_dev_ack,
  input  logic [be_pkg::CPU_WIDTH-1:0]  i_dev_rdata,

  // register read port
  input  logic [be_pkg::REG_ADDRW-1:0]  i_rs_id,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_rs_data,

  // writeback trace
  output logic                          o_wb_rdwen,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_wb_rd,
  output logic [be_pkg::REG_ADDRW-1:0]  o_wb_rdid,
  output logic [be_pkg::CPU_WIDTH-1:0]  o_wb_pc,
  output logic [be_pkg::INS_WIDTH-1:0]  o_wb_ins,
  output logic                          o_wb_device
);

  import be_pkg::*;

  // lsu to wbu
  logic                 lsu_valid;
  logic                 wbu_ready;
  logic [CPU_WIDTH-1:0] lsu_exres;
  logic [CPU_WIDTH-1:0] lsu_lsres;
  logic [REG_ADDRW-1:0] lsu_rdid;
  logic                 lsu_rdwen;
  logic                 lsu_lden;
  logic [CPU_WIDTH-1:0] lsu_pc;
  logic [INS_WIDTH-1:0] lsu_ins;
  logic                 lsu_device;

  // lsu to dmem
  logic [DMEM_IDXW-1:0] mem_idx;
  logic [BE_WIDTH-1:0]  mem_be;
  logic [CPU_WIDTH-1:0] mem_wdata;
  logic                 mem_we;
  logic [CPU_WIDTH-1:0] mem_rdata;

  lsu lsu_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (i_exu_valid),
    .o_pre_ready  (o_exu_ready),
    .i_exu_exres  (i_exu_exres),
    .i_exu_rs2    (i_exu_rs2),
    .i_exu_rdid   (i_exu_rdid),
    .i_exu_rdwen  (i_exu_rdwen),
    .i_exu_lsop   (i_exu_lsop),
    .i_exu_pc     (i_exu_pc),
    .i_exu_ins    (i_exu_ins),
    .o_post_valid (lsu_valid),
    .i_post_ready (wbu_ready),
    .o_lsu_exres  (lsu_exres),
    .o_lsu_lsres  (lsu_lsres),
    .o_lsu_rdid   (lsu_rdid),
    .o_lsu_rdwen  (lsu_rdwen),
    .o_lsu_lden   (lsu_lden),
    .o_lsu_pc     (lsu_pc),
    .o_lsu_ins    (lsu_ins),
    .o_lsu_device (lsu_device),
    .o_mem_idx    (mem_idx),
    .o_mem_be     (mem_be),
    .o_mem_wdata  (mem_wdata),
    .o_mem_we     (mem_we),
    .i_mem_rdata  (mem_rdata),
    .o_dev_req    (o_dev_req),
    .o_dev_addr   (o_dev_addr),
    .o_dev_we     (o_dev_we),
    .o_dev_be     (o_dev_be),
    .o_dev_wdata  (o_dev_wdata),
    .i_dev_ack    (i_dev_ack),
    .i_dev_rdata  (i_dev_rdata)
  );

  dmem dmem_i (
    .i_clk       (i_clk),
    .i_mem_idx   (mem_idx),
    .i_mem_be    (mem_be),
    .i_mem_wdata (mem_wdata),
    .i_mem_we    (mem_we),
    .o_mem_rdata (mem_rdata)
  );

  wbu wbu_i (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (lsu_valid),
    .o_pre_ready  (wbu_ready),
    .i_lsu_exres  (lsu_exres),
    .i_lsu_lsres  (lsu_lsres),
    .i_lsu_rdid   (lsu_rdid),
    .i_lsu_rdwen  (lsu_rdwen),
    .i_lsu_lden   (lsu_lden),
    .i_lsu_pc     (lsu_pc),
    .i_lsu_ins    (lsu_ins),
    .i_lsu_device (lsu_device),
    .o_wbu_rdwen  (o_wb_rdwen),
    .o_wbu_rd     (o_wb_rd),
    .o_wbu_rdid   (o_wb_rdid),
    .o_wbu_pc     (o_wb_pc),
    .o_wbu_ins    (o_wb_ins),
    .o_wbu_device (o_wb_device)
  );

  // write port is fed straight from the writeback trace outputs
  regfile regfile_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wen   (o_wb_rdwen),
    .i_wid   (o_wb_rdid),
    .i_wdata (o_wb_rd),
    .i_rid   (i_rs_id),
    .o_rdata (o_rs_data)
  );

endmodule

// File: verification/be_tb.sv
`timescale 1ns/10ps

module be_tb;

  import be_pkg::*;

  localparam logic [31:0] LOC_BASE = 32'h0000_0100;
  localparam logic [31:0] DEV_BASE = 32'h8000_0000;

  typedef struct packed {
    logic [4:0]  rdid;
    logic [31:0] rd;
    logic [31:0] pc;
    logic [31:0] ins;
    logic        device;
  } wb_exp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } dev_exp_t;

  logic                 i_clk;
  logic                 i_rst_n;
  logic                 i_exu_valid;
  logic                 o_exu_ready;
  logic [31:0]          i_exu_exres;
  logic [31:0]          i_exu_rs2;
  logic [4:0]           i_exu_rdid;
  logic                 i_exu_rdwen;
  lsu_op_e              i_exu_lsop;
  logic [31:0]          i_exu_pc;
  logic [31:0]          i_exu_ins;
  logic                 o_dev_req;
  logic [31:0]          o_dev_addr;
  logic                 o_dev_we;
  logic [3:0]           o_dev_be;
  logic [31:0]          o_dev_wdata;
  logic                 i_dev_ack;
  logic [31:0]          i_dev_rdata;
  logic [4:0]           i_rs_id;
  logic [31:0]          o_rs_data;
  logic                 o_wb_rdwen;
  logic [31:0]          o_wb_rd;
  logic [4:0]           o_wb_rdid;
  logic [31:0]          o_wb_pc;
  logic [31:0]          o_wb_ins;
  logic                 o_wb_device;

  int                   seed = 27456;
  int                   stim_seed = 27456;
  int                   n_issued = 0;
  logic [31:0]          pc = 32'h0000_1000;
  logic                 prev_dev = 1'b0;
  // reference models of the registers, local words and device words
  logic [31:0]          reg_ref [32];
  logic [31:0]          loc_ref [16];
  logic [31:0]          dev_ref [16];
  // contents of the modelled device itself
  logic [31:0]          dev_mem [16];
  wb_exp_t              wb_q [$];
  dev_exp_t             dev_q [$];

  be_top dut_i (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [3:0] lane_enables(input lsu_op_e op, input logic [1:0] lane);
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: return 4'b0001 << lane;
      LSU_LH, LSU_LHU, LSU_SH: return lane[1] ? 4'b1100 : 4'b0011;
      LSU_LW, LSU_SW:          return 4'b1111;
      default:                 return 4'b0000;
    endcase
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // byte and half come from the lane picked by the low address bits
  function automatic logic [31:0] extend_load(input lsu_op_e op, input logic [31:0] word,
                                              input logic [1:0] lane);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*lane +: 8];
    h = word[16*lane[1] +: 16];
    case (op)
      LSU_LB:  return {{24{b[7]}}, b};
      LSU_LBU: return {24'b0, b};
      LSU_LH:  return {{16{h[15]}}, h};
      LSU_LHU: return {16'b0, h};
      default: return word;
    endcase
  endfunction

  function automatic logic [31:0] device_fill(input int idx);
    logic [31:0] a;
    a = DEV_BASE | (idx << 2);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic issue_instr(input lsu_op_e op, input logic [31:0] res,
                             input logic [31:0] rs2, input logic [4:0] rd, input logic rdwen);
    logic        is_ld;
    logic        is_st;
    logic        dev;
    logic [3:0]  be;
    logic [31:0] mask;
    logic [31:0] word;
    logic [31:0] result;
    logic [31:0] ins;
    is_ld  = op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU};
    is_st  = op inside {LSU_SB, LSU_SH, LSU_SW};
    dev    = (is_ld || is_st) && res[DEV_BIT];
    be     = lane_enables(op, res[1:0]);
    mask   = byte_mask(be);
    word   = dev ? dev_ref[res[5:2]] : loc_ref[res[5:2]];
    result = is_ld ? extend_load(op, word, res[1:0]) : res;
    ins    = $random(stim_seed);
    if (is_st) begin
      word = (word & ~mask) | ((rs2 << (8 * res[1:0])) & mask);
      if (dev) begin
        dev_ref[res[5:2]] = word;
      end else begin
        loc_ref[res[5:2]] = word;
      end
    end
    if (dev) begin
      dev_q.push_back('{res, is_st, be, rs2 << (8 * res[1:0])});
    end
    if (rdwen) begin
      wb_q.push_back('{rd, result, pc, ins, dev});
    end
    if (rdwen && rd != 5'd0) begin
      reg_ref[rd] = result;
    end
    i_exu_valid = 1'b1;
    i_exu_lsop  = op;
    i_exu_exres = res;
    i_exu_rs2   = rs2;
    i_exu_rdid  = rd;
    i_exu_rdwen = rdwen;
    i_exu_pc    = pc;
    i_exu_ins   = ins;
    n_issued++;
    #1;
    // a local access ahead never stalls the stage
    if (!prev_dev) begin
      compare_value("o_exu_ready", o_exu_ready, 1'b1);
    end
    while (!o_exu_ready) begin
      @(negedge i_clk);
      #1;
    end
    @(posedge i_clk);
    @(negedge i_clk);
    i_exu_valid = 1'b0;
    prev_dev    = dev;
    pc          = pc + 4;
  endtask

  task automatic drain_pipeline();
    while (wb_q.size() != 0 || dev_q.size() != 0) begin
      @(negedge i_clk);
    end
    repeat (3) @(negedge i_clk);
  endtask

  task automatic read_back_regs();
    for (int r = 0; r < 32; r++) begin
      @(negedge i_clk);
      i_rs_id = 5'(r);
      #1;
      compare_value($sformatf("o_rs_data x%0d", r), o_rs_data, reg_ref[r]);
    end
    @(negedge i_clk);
  endtask

  task automatic pass_through_test();
    for (int r = 1; r <= 8; r++) begin
      issue_instr(LSU_NONE, $random(stim_seed), 32'h0, 5'(r), 1'b1);
    end
    drain_pipeline();
    read_back_regs();
  endtask

  task automatic local_mem_test();
    logic [31:0] a;
    // fill every local word first so later loads never see undefined data
    for (int w = 0; w < 16; w++) begin
      issue_instr(LSU_SW, LOC_BASE + 4 * w, $random(stim_seed), 5'd0, 1'b0);
    end
    for (int w = 0; w < 4; w++) begin
      a = LOC_BASE + 4 * w;
      issue_instr(LSU_SH, a + 2, $random(stim_seed), 5'd0, 1'b0);
      issue_instr(LSU_SB, a + 1, $random(stim_seed), 5'd0, 1'b0);
      for (int l = 0; l < 4; l++) begin
        issue_instr(LSU_LB, a + l, 32'h0, 5'(10 + l), 1'b1);
        issue_instr(LSU_LBU, a + l, 32'h0, 5'(14 + l), 1'b1);
      end
      for (int h = 0; h < 4; h += 2) begin
        issue_instr(LSU_LH, a + h, 32'h0, 5'(18 + h), 1'b1);
        issue_instr(LSU_LHU, a + h, 32'h0, 5'(19 + h), 1'b1);
      end
      issue_instr(LSU_LW, a, 32'h0, 5'd22, 1'b1);
    end
    drain_pipeline();
    read_back_regs();
  endtask

  task automatic device_test();
    logic [31:0] a;
    for (int w = 0; w < 3; w++) begin
      a = DEV_BASE + 4 * w;
      issue_instr(LSU_SW, a, $random(stim_seed), 5'd0, 1'b0);
      issue_instr(LSU_LW, a, 32'h0, 5'd23, 1'b1);
      issue_instr(LSU_SB, a + 3, 32'h0000_0080 + w, 5'd0, 1'b0);
      issue_instr(LSU_LB, a + 3, 32'h0, 5'd24, 1'b1);
      issue_instr(LSU_LBU, a + 3, 32'h0, 5'd25, 1'b1);
      issue_instr(LSU_SH, a + 2, 32'h0000_8001 + w, 5'd0, 1'b0);
      issue_instr(LSU_LH, a + 2, 32'h0, 5'd26, 1'b1);
      issue_instr(LSU_LHU, a, 32'h0, 5'd27, 1'b1);
    end
    // untouched word returns its fill pattern
    issue_instr(LSU_LW, DEV_BASE + 4 * 9, 32'h0, 5'd28, 1'b1);
    drain_pipeline();
    read_back_regs();
  endtask

  task automatic suppress_test();
    issue_instr(LSU_NONE, 32'hdead_beef, 32'h0, 5'd5, 1'b0);
    issue_instr(LSU_LW, LOC_BASE, 32'h0, 5'd6, 1'b0);
    issue_instr(LSU_NONE, 32'h1234_5678, 32'h0, 5'd0, 1'b1);
    issue_instr(LSU_LW, DEV_BASE, 32'h0, 5'd0, 1'b1);
    drain_pipeline();
    read_back_regs();
  endtask

  task automatic mixed_stream_test();
    lsu_op_e     op;
    logic [31:0] a;
    logic [1:0]  lane;
    int          kind;
    for (int i = 0; i < 200; i++) begin
      kind = $unsigned($random(stim_seed)) % 8;
      op   = lsu_op_e'(4'(1 + $unsigned($random(stim_seed)) % 8));
      lane = 2'($random(stim_seed));
      if (op inside {LSU_LH, LSU_LHU, LSU_SH}) begin
        lane[0] = 1'b0;
      end
      if (op inside {LSU_LW, LSU_SW}) begin
        lane = 2'b00;
      end
      a = (kind < 6 ? LOC_BASE : DEV_BASE) + 4 * ($unsigned($random(stim_seed)) % 16) + lane;
      if (kind < 3) begin
        op = LSU_NONE;
        a  = $random(stim_seed);
      end
      issue_instr(op, a, $random(stim_seed), 5'($random(stim_seed)),
                  !(op inside {LSU_SB, LSU_SH, LSU_SW}) && ($random(stim_seed) % 4 != 0));
      if ($unsigned($random(stim_seed)) % 4 == 0) begin
        repeat (1 + $unsigned($random(stim_seed)) % 3) @(negedge i_clk);
      end
    end
    drain_pipeline();
    read_back_regs();
  endtask

  // device model that answers each request after 0 to 5 cycles
  initial begin : device_responder
    int          delay;
    dev_exp_t    d;
    logic [31:0] mask;
    @(posedge i_rst_n);
    forever begin
      @(negedge i_clk);
      if (o_dev_req) begin
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) @(negedge i_clk);
        if (dev_q.size() == 0) begin
          abort_run("device request seen with no device access issued");
        end else begin
          d    = dev_q.pop_front();
          mask = byte_mask(o_dev_be);
          compare_value("o_dev_addr", o_dev_addr, d.addr);
          compare_value("o_dev_we", o_dev_we, d.we);
          compare_value("o_dev_be", o_dev_be, d.be);
          if (o_dev_we) begin
            compare_value("o_dev_wdata", o_dev_wdata & mask, d.wdata & mask);
            dev_mem[o_dev_addr[5:2]] = (dev_mem[o_dev_addr[5:2]] & ~mask) |
                                       (o_dev_wdata & mask);
          end
          i_dev_rdata = dev_mem[o_dev_addr[5:2]];
          i_dev_ack   = 1'b1;
          @(negedge i_clk);
          i_dev_ack   = 1'b0;
        end
      end
    end
  end

  always @(negedge i_clk) begin : wb_monitor
    wb_exp_t e;
    if (i_rst_n && o_wb_rdwen) begin
      if (wb_q.size() == 0) begin
        abort_run("register write seen with no instruction outstanding");
      end else begin
        e = wb_q.pop_front();
        compare_value("o_wb_rdid", o_wb_rdid, e.rdid);
        compare_value("o_wb_rd", o_wb_rd, e.rd);
        compare_value("o_wb_pc", o_wb_pc, e.pc);
        compare_value("o_wb_ins", o_wb_ins, e.ins);
        compare_value("o_wb_device", o_wb_device, e.device);
      end
    end
  end

  // a pending device access holds off the execute side
  always @(negedge i_clk) begin
    #1;
    if (i_rst_n && o_dev_req && !i_dev_ack) begin
      compare_value("o_exu_ready", o_exu_ready, 1'b0);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge i_clk);
      cycles++;
      if (cycles > n_issued * 20 + 200) begin
        abort_run("watchdog expired before the tests finished");
      end
    end
  end

  initial begin
    i_rst_n     = 1'b0;
    i_exu_valid = 1'b0;
    i_exu_exres = '0;
    i_exu_rs2   = '0;
    i_exu_rdid  = '0;
    i_exu_rdwen = 1'b0;
    i_exu_lsop  = LSU_NONE;
    i_exu_pc    = '0;
    i_exu_ins   = '0;
    i_dev_ack   = 1'b0;
    i_dev_rdata = '0;
    i_rs_id     = '0;
    for (int i = 0; i < 32; i++) begin
      reg_ref[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      dev_mem[i] = device_fill(i);
      dev_ref[i] = device_fill(i);
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n = 1'b1;
    pass_through_test();
    local_mem_test();
    device_test();
    suppress_test();
    mixed_stream_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: src.f
hdl/be_pkg.sv
hdl/lsu.sv
hdl/dmem.sv
hdl/wbu.sv
hdl/regfile.sv
hdl/be_top.sv
verification/be_tb.sv

// File: Bender.yml
package:
  name: rv32_backend

sources:
  - files:
      - hdl/be_pkg.sv
      - hdl/lsu.sv
      - hdl/dmem.sv
      - hdl/wbu.sv
      - hdl/regfile.sv
      - hdl/be_top.sv
  - target: simulation
    files:
      - verification/be_tb.sv
